//--- sim/fb_memif_trace.txt
// frame_bytes  enable_pattern  cmd_full_stall_pct  frames   (all hex, one test per line)
// enable_pattern gives 2 bits per frame: 0 full frame, 1 enable low at vsync, 2 drop mid-frame
0400 00 00 3
0800 00 19 3
0200 04 0a 3
0800 20 0f 3
0000 00 00 0

//--- fb_memif_top.f
+incdir+design
design/fb_mem_pkg.sv
design/fb_ctrl_pkg.sv
design/wr_burst_seq.sv
design/rd_burst_seq.sv
design/cmd_arbiter.sv
design/fb_memif_top.sv
sim/mig_port_model.sv
sim/fb_memif_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fb_memif_tb
FILELIST = fb_memif_top.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/fb_memif_tb.sv
// Trace-driven testbench with producer, consumer, command monitor, checkers and timeout
`timescale 1ns/100ps
`include "fb_memif_cfg.svh"

module fb_memif_tb;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   enable;
    logic                   vsync;
    fb_mem_pkg::byte_addr_t frame_bytes;
    fb_mem_pkg::word_t      pix_write;
    logic                   pix_write_valid;
    logic                   pix_write_ready;
    fb_mem_pkg::word_t      pix_read;
    logic                   pix_read_valid;
    logic                   pix_read_ready = 1'b0;
    logic                   mig_cmd_en;
    fb_mem_pkg::cmd_instr_t mig_cmd_instr;
    fb_mem_pkg::bl_t        mig_cmd_bl;
    fb_mem_pkg::mig_addr_t  mig_cmd_byte_addr;
    logic                   mig_cmd_full;
    logic                   mig_wr_en;
    fb_mem_pkg::mask_t      mig_wr_mask;
    fb_mem_pkg::word_t      mig_wr_data;
    logic                   mig_wr_full;
    logic                   mig_rd_en;
    fb_mem_pkg::word_t      mig_rd_data;
    logic                   mig_rd_empty;
    logic [7:0]             stall_pct;

    logic [31:0]            trace [0:63];
    fb_mem_pkg::word_t      shadow [256];
    fb_mem_pkg::word_t      produced [$];
    fb_mem_pkg::word_t      exp_rd [$];
    fb_mem_pkg::mig_addr_t  exp_wr_addr;
    fb_mem_pkg::mig_addr_t  exp_rd_addr;
    fb_mem_pkg::cmd_instr_t last_instr;
    fb_mem_pkg::word_t      prev_word;
    logic                   prev_accept;
    logic                   prev_cmd_en;
    logic                   prev_cmd_full;
    logic                   prev_both;
    int                     wr_cmds = 0;
    int                     rd_cmds = 0;
    int                     errors = 0;
    int                     checks = 0;
    int                     cycles = 0;
    int                     limit = 0;

    fb_memif_top DUT (.*);

    mig_port_model model (
        .clk       (clk),
        .rst       (rst),
        .stall_pct (stall_pct),
        .cmd_en    (mig_cmd_en),
        .cmd_instr (mig_cmd_instr),
        .cmd_addr  (mig_cmd_byte_addr),
        .cmd_full  (mig_cmd_full),
        .wr_en     (mig_wr_en),
        .wr_data   (mig_wr_data),
        .wr_full   (mig_wr_full),
        .rd_en     (mig_rd_en),
        .rd_data   (mig_rd_data),
        .rd_empty  (mig_rd_empty)
    );

    always #4 clk = ~clk;

    task automatic flag_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_word(input string name, input fb_mem_pkg::word_t exp,
                              input fb_mem_pkg::word_t got);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input fb_mem_pkg::mig_addr_t exp,
                              input fb_mem_pkg::mig_addr_t got);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_bl(input fb_mem_pkg::bl_t exp, input fb_mem_pkg::bl_t got);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH mig_cmd_bl expected %h got %h", exp, got);
            errors++;
        end
    endtask

    task automatic check_mask(input fb_mem_pkg::mask_t exp, input fb_mem_pkg::mask_t got);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH mig_wr_mask expected %h got %h", exp, got);
            errors++;
        end
    endtask

    // Producer offers n words with random gaps and holds each one until accepted
    task automatic produce(input int n);
        int  k;
        logic taken;
        k = 0;
        while (k < n) begin
            if (!pix_write_valid && ($urandom_range(0, 3) != 0)) begin
                pix_write       = {$urandom, $urandom, $urandom, $urandom};
                pix_write_valid = 1'b1;
            end
            @(posedge clk);
            taken = pix_write_valid && pix_write_ready;
            #1;
            if (taken) begin
                k++;
                pix_write_valid = 1'b0;
            end
        end
    endtask

    // Consumer with random ready gaps
    always begin
        @(posedge clk);
        #1;
        pix_read_ready = ($urandom_range(0, 3) != 0);
    end

    always @(posedge clk) begin
        cycles++;
        if ((limit != 0) && (cycles > limit)) begin
            $display("Timeout after %0d cycles, a frame never completed", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Shadow memory follows commands in issue order, the same order the controller runs them
    always @(posedge clk) begin
        int idx;
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                shadow[i] = '0;
            end
            last_instr    = fb_mem_pkg::CMD_WRITE;
            prev_accept   = 1'b0;
            prev_word     = '0;
            prev_cmd_en   = 1'b0;
            prev_cmd_full = 1'b0;
            prev_both     = 1'b0;
        end else begin
            if (vsync) begin
                exp_wr_addr = '0;
                exp_rd_addr = '0;
            end
            // Each accepted word reaches the write FIFO in the next cycle, unmasked
            if (mig_wr_en !== prev_accept) begin
                flag_error("mig_wr_en did not follow pixel acceptance by one cycle");
            end
            if (mig_wr_en) begin
                check_word("mig_wr_data", prev_word, mig_wr_data);
                check_mask(fb_mem_pkg::mask_t'(0), mig_wr_mask);
            end
            if (pix_write_valid && pix_write_ready) begin
                produced.push_back(pix_write);
                if (mig_wr_full) begin
                    flag_error("pix_write_ready high while the write FIFO is full");
                end
            end
            if (pix_read_valid) begin
                if (exp_rd.size() == 0) begin
                    flag_error("pix_read word delivered with no read outstanding");
                end else begin
                    check_word("pix_read", exp_rd.pop_front(), pix_read);
                end
            end
            if (mig_cmd_en) begin
                idx = int'(mig_cmd_byte_addr / `FB_WORD_BYTES);
                if (prev_cmd_en) begin
                    flag_error("mig_cmd_en high in two adjacent cycles");
                end
                if (prev_cmd_full) begin
                    flag_error("command issued while mig_cmd_full was high");
                end
                check_bl(fb_mem_pkg::bl_t'(7), mig_cmd_bl);
                if (prev_both && (mig_cmd_instr == last_instr)) begin
                    flag_error("arbiter did not alternate with both requests pending");
                end
                last_instr = mig_cmd_instr;
                if (mig_cmd_instr == fb_mem_pkg::CMD_WRITE) begin
                    check_addr("mig_cmd_byte_addr", exp_wr_addr, mig_cmd_byte_addr);
                    exp_wr_addr = exp_wr_addr + fb_mem_pkg::mig_addr_t'(`FB_CMD_BYTES);
                    wr_cmds++;
                    if (produced.size() < `FB_BURST_LEN) begin
                        flag_error("write command issued before a full burst was accepted");
                    end else begin
                        for (int i = 0; i < `FB_BURST_LEN; i++) begin
                            shadow[(idx + i) % 256] = produced.pop_front();
                        end
                    end
                end else begin
                    check_addr("mig_cmd_byte_addr", exp_rd_addr, mig_cmd_byte_addr);
                    exp_rd_addr = exp_rd_addr + fb_mem_pkg::mig_addr_t'(`FB_CMD_BYTES);
                    rd_cmds++;
                    for (int i = 0; i < `FB_BURST_LEN; i++) begin
                        exp_rd.push_back(shadow[(idx + i) % 256]);
                    end
                end
            end
            prev_accept   = pix_write_valid && pix_write_ready;
            prev_word     = pix_write;
            prev_cmd_en   = mig_cmd_en;
            prev_cmd_full = mig_cmd_full;
            prev_both     = DUT.wr_req && !DUT.wr_done && DUT.rd_req && !DUT.rd_done;
        end
    end

    // Mode 0 runs a full frame, 1 has enable low at vsync, 2 drops enable mid-frame
    task automatic run_frame(input int ncmd, input int mode);
        int base_wr;
        int base_rd;
        int target;
        int rd_at_drop;
        int idle;
        int seen;
        logic busy;
        fb_mem_pkg::mig_addr_t drop_addr;
        target     = (mode == 1) ? 1 : ((mode == 2) ? ncmd / 2 : ncmd);
        drop_addr  = fb_mem_pkg::mig_addr_t'((target - 1) * `FB_CMD_BYTES);
        rd_at_drop = 0;
        @(posedge clk);
        #1;
        base_wr = wr_cmds;
        base_rd = rd_cmds;
        vsync   = 1'b1;
        enable  = (mode != 1);
        @(posedge clk);
        #1;
        vsync = 1'b0;
        fork
            produce(target * `FB_BURST_LEN);
            begin
                if (mode == 2) begin
                    do begin
                        @(posedge clk);
                    end while (!(mig_cmd_en && (mig_cmd_instr == fb_mem_pkg::CMD_WRITE)
                                 && (mig_cmd_byte_addr == drop_addr)));
                    #1;
                    enable     = 1'b0;
                    rd_at_drop = rd_cmds - base_rd;
                end
            end
        join
        // Frame is over once its commands are in and no command shows up for a while
        idle = 0;
        seen = wr_cmds + rd_cmds;
        while (idle < 40) begin
            @(posedge clk);
            #1;
            busy = (wr_cmds + rd_cmds != seen) || (exp_rd.size() != 0)
                   || (wr_cmds - base_wr < target)
                   || ((mode == 0) && (rd_cmds - base_rd < ncmd));
            seen = wr_cmds + rd_cmds;
            idle = busy ? 0 : idle + 1;
        end
        if (wr_cmds - base_wr != target) begin
            flag_error($sformatf("frame issued %0d write commands instead of %0d",
                                 wr_cmds - base_wr, target));
        end
        if ((mode == 0) && (rd_cmds - base_rd != ncmd)) begin
            flag_error("full frame did not read back every burst");
        end
        if ((mode == 1) && (rd_cmds != base_rd)) begin
            flag_error("read command issued with enable low at vsync");
        end
        if ((mode == 2) && (rd_cmds - base_rd > rd_at_drop + 1)) begin
            flag_error("more than one read command after enable dropped");
        end
    endtask

    initial begin
        int t;
        int ncmd;
        int frames;
        int err_before;
        logic [31:0] pattern;
        void'($urandom(32'h7afa471b));
        rst             = 1'b1;
        enable          = 1'b0;
        vsync           = 1'b0;
        frame_bytes     = '0;
        pix_write       = '0;
        pix_write_valid = 1'b0;
        stall_pct       = '0;
        for (int i = 0; i < 64; i++) begin
            trace[i] = '0;
        end
        $readmemh("sim/fb_memif_trace.txt", trace);
        t = 0;
        while ((t < 16) && (trace[4*t] != 0)) begin
            limit += int'(trace[4*t+3]) * (2 * (int'(trace[4*t]) / `FB_CMD_BYTES) * 40 + 200);
            t++;
        end
        limit += 1000;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        t = 0;
        while ((t < 16) && (trace[4*t] != 0)) begin
            frame_bytes = fb_mem_pkg::byte_addr_t'(trace[4*t]);
            pattern     = trace[4*t+1];
            stall_pct   = trace[4*t+2][7:0];
            frames      = int'(trace[4*t+3]);
            ncmd        = int'(frame_bytes) / `FB_CMD_BYTES;
            err_before  = errors;
            for (int f = 0; f < frames; f++) begin
                run_frame(ncmd, int'((pattern >> (2 * f)) & 32'd3));
            end
            $display("test %0d: %0d bytes, %0d frames, stall %0d%%, %0d errors",
                     t, ncmd * `FB_CMD_BYTES, frames, stall_pct, errors - err_before);
            t++;
        end
        $display("%0d tests, %0d checks, %0d errors", t, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- sim/mig_port_model.sv
// Behavioural DDR controller user port with command, write and read FIFOs over a word array
`timescale 1ns/100ps
`include "fb_memif_cfg.svh"

module mig_port_model #(
    parameter int MEM_WORDS = 256,
    parameter int RD_DELAY  = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             stall_pct,
    input  logic                   cmd_en,
    input  fb_mem_pkg::cmd_instr_t cmd_instr,
    input  fb_mem_pkg::mig_addr_t  cmd_addr,
    output logic                   cmd_full,
    input  logic                   wr_en,
    input  fb_mem_pkg::word_t      wr_data,
    output logic                   wr_full,
    input  logic                   rd_en,
    output fb_mem_pkg::word_t      rd_data,
    output logic                   rd_empty
);

    fb_mem_pkg::word_t      mem [MEM_WORDS];
    fb_mem_pkg::cmd_instr_t instr_q [$];
    fb_mem_pkg::mig_addr_t  addr_q [$];
    fb_mem_pkg::word_t      wr_q [$];
    fb_mem_pkg::word_t      rd_q [$];
    int                     delay;
    int                     base;

    always @(posedge clk) begin
        if (rst) begin
            instr_q.delete();
            addr_q.delete();
            wr_q.delete();
            rd_q.delete();
            delay = 0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] = '0;
            end
            cmd_full <= 1'b0;
            wr_full  <= 1'b0;
        end else begin
            if (cmd_en) begin
                instr_q.push_back(cmd_instr);
                addr_q.push_back(cmd_addr);
            end
            if (wr_en) begin
                wr_q.push_back(wr_data);
            end
            if (rd_en && (rd_q.size() != 0)) begin
                void'(rd_q.pop_front());
            end
            // Head command runs once its data is there, reads after a short latency
            if (instr_q.size() != 0) begin
                base = int'(addr_q[0] / `FB_WORD_BYTES);
                if (instr_q[0] == fb_mem_pkg::CMD_WRITE) begin
                    if (wr_q.size() >= `FB_BURST_LEN) begin
                        for (int i = 0; i < `FB_BURST_LEN; i++) begin
                            mem[(base + i) % MEM_WORDS] = wr_q.pop_front();
                        end
                        void'(instr_q.pop_front());
                        void'(addr_q.pop_front());
                    end
                end else if (delay < RD_DELAY) begin
                    delay = delay + 1;
                end else begin
                    delay = 0;
                    for (int i = 0; i < `FB_BURST_LEN; i++) begin
                        rd_q.push_back(mem[(base + i) % MEM_WORDS]);
                    end
                    void'(instr_q.pop_front());
                    void'(addr_q.pop_front());
                end
            end
            cmd_full <= (instr_q.size() >= 4) || ($urandom_range(0, 99) < 32'(stall_pct));
            wr_full  <= (wr_q.size() >= 48) || ($urandom_range(0, 99) < 32'(stall_pct));
        end
        rd_empty <= (rd_q.size() == 0);
        rd_data  <= (rd_q.size() != 0) ? rd_q[0] : '0;
    end

endmodule

//--- design/fb_memif_top.sv
// Framebuffer memory port top level joining write sequencer, read sequencer and arbiter
`timescale 1ns/100ps
`include "fb_memif_cfg.svh"

module fb_memif_top (
    input  logic                      clk,
    input  logic                      rst,
    // Frame control
    input  logic                      enable,
    input  logic                      vsync,
    input  fb_mem_pkg::byte_addr_t    frame_bytes,
    // Pixel write port
    input  fb_mem_pkg::word_t         pix_write,
    input  logic                      pix_write_valid,
    output logic                      pix_write_ready,
    // Pixel read port
    output fb_mem_pkg::word_t         pix_read,
    output logic                      pix_read_valid,
    input  logic                      pix_read_ready,
    // DDR controller command port
    output logic                      mig_cmd_en,
    output fb_mem_pkg::cmd_instr_t    mig_cmd_instr,
    output fb_mem_pkg::bl_t           mig_cmd_bl,
    output fb_mem_pkg::mig_addr_t     mig_cmd_byte_addr,
    input  logic                      mig_cmd_full,
    // DDR controller write FIFO
    output logic                      mig_wr_en,
    output fb_mem_pkg::mask_t         mig_wr_mask,
    output fb_mem_pkg::word_t         mig_wr_data,
    input  logic                      mig_wr_full,
    // DDR controller read FIFO
    output logic                      mig_rd_en,
    input  fb_mem_pkg::word_t         mig_rd_data,
    input  logic                      mig_rd_empty
);

    logic                   wr_req;
    fb_mem_pkg::byte_addr_t wr_addr;
    logic                   wr_done;
    logic                   rd_req;
    fb_mem_pkg::byte_addr_t rd_addr;
    logic                   rd_done;

    wr_burst_seq u_wr_seq (
        .clk             (clk),
        .rst             (rst),
        .enable          (enable),
        .vsync           (vsync),
        .frame_bytes     (frame_bytes),
        .pix_write       (pix_write),
        .pix_write_valid (pix_write_valid),
        .pix_write_ready (pix_write_ready),
        .mig_wr_full     (mig_wr_full),
        .mig_wr_en       (mig_wr_en),
        .mig_wr_data     (mig_wr_data),
        .mig_wr_mask     (mig_wr_mask),
        .wr_req          (wr_req),
        .wr_addr         (wr_addr),
        .wr_done         (wr_done)
    );

    rd_burst_seq u_rd_seq (
        .clk            (clk),
        .rst            (rst),
        .enable         (enable),
        .vsync          (vsync),
        .frame_bytes    (frame_bytes),
        .pix_read       (pix_read),
        .pix_read_valid (pix_read_valid),
        .pix_read_ready (pix_read_ready),
        .mig_rd_en      (mig_rd_en),
        .mig_rd_data    (mig_rd_data),
        .mig_rd_empty   (mig_rd_empty),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .rd_done        (rd_done)
    );

    cmd_arbiter u_arb (
        .clk               (clk),
        .rst               (rst),
        .wr_req            (wr_req),
        .wr_addr           (wr_addr),
        .wr_done           (wr_done),
        .rd_req            (rd_req),
        .rd_addr           (rd_addr),
        .rd_done           (rd_done),
        .mig_cmd_full      (mig_cmd_full),
        .mig_cmd_en        (mig_cmd_en),
        .mig_cmd_instr     (mig_cmd_instr),
        .mig_cmd_bl        (mig_cmd_bl),
        .mig_cmd_byte_addr (mig_cmd_byte_addr)
    );

endmodule

//--- design/cmd_arbiter.sv
// Round-robin command arbiter that puts read and write bursts onto the controller command port
`timescale 1ns/100ps
`include "fb_memif_cfg.svh"

module cmd_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_req,
    input  fb_mem_pkg::byte_addr_t    wr_addr,
    output logic                      wr_done,
    input  logic                      rd_req,
    input  fb_mem_pkg::byte_addr_t    rd_addr,
    output logic                      rd_done,
    input  logic                      mig_cmd_full,
    output logic                      mig_cmd_en,
    output fb_mem_pkg::cmd_instr_t    mig_cmd_instr,
    output fb_mem_pkg::bl_t           mig_cmd_bl,
    output fb_mem_pkg::mig_addr_t     mig_cmd_byte_addr
);

    fb_ctrl_pkg::issue_state_t state;
    logic                      wr_first;
    logic                      rd_pending;
    logic                      wr_pending;
    logic                      pick_rd;
    logic                      pick_wr;
    logic                      launch;

    // A request whose done is out this cycle is already served
    assign rd_pending = rd_req && !rd_done;
    assign wr_pending = wr_req && !wr_done;

    // Pointer low favours reads, high favours writes
    assign pick_rd = rd_pending && (!wr_first || !wr_pending);
    assign pick_wr = wr_pending && !pick_rd;
    assign launch  = (state == fb_ctrl_pkg::ISSUE_WAIT) && !mig_cmd_full
                     && (pick_rd || pick_wr);

    assign mig_cmd_bl = fb_mem_pkg::bl_t'(`FB_BURST_LEN - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= fb_ctrl_pkg::ISSUE_WAIT;
            mig_cmd_en <= 1'b0;
            wr_done    <= 1'b0;
            rd_done    <= 1'b0;
            wr_first   <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            rd_done <= 1'b0;
            case (state)
                fb_ctrl_pkg::ISSUE_WAIT: begin
                    if (launch) begin
                        mig_cmd_en <= 1'b1;
                        wr_first   <= pick_rd;
                        state      <= fb_ctrl_pkg::ISSUE_ACT;
                    end
                end
                fb_ctrl_pkg::ISSUE_ACT: begin
                    // Command is on the port now, acknowledge it next cycle
                    mig_cmd_en <= 1'b0;
                    rd_done    <= (mig_cmd_instr == fb_mem_pkg::CMD_READ);
                    wr_done    <= (mig_cmd_instr == fb_mem_pkg::CMD_WRITE);
                    state      <= fb_ctrl_pkg::ISSUE_WAIT;
                end
                default: state <= fb_ctrl_pkg::ISSUE_WAIT;
            endcase
        end
    end

    // Opcode and address of the winning request
    always_ff @(posedge clk) begin
        if (launch) begin
            if (pick_rd) begin
                mig_cmd_instr     <= fb_mem_pkg::CMD_READ;
                mig_cmd_byte_addr <= fb_mem_pkg::mig_addr_t'(rd_addr);
            end else begin
                mig_cmd_instr     <= fb_mem_pkg::CMD_WRITE;
                mig_cmd_byte_addr <= fb_mem_pkg::mig_addr_t'(wr_addr);
            end
        end
    end

    a_cmd_spacing: assert property (@(posedge clk) disable iff (rst)
        mig_cmd_en |=> !mig_cmd_en);

    // Full flag is sampled in the cycle before the command appears
    a_cmd_not_full: assert property (@(posedge clk) disable iff (rst)
        $rose(mig_cmd_en) |-> !$past(mig_cmd_full));

endmodule

//--- design/rd_burst_seq.sv
// Read burst sequencer: burst read requests and zero-latency streaming of the read FIFO
`timescale 1ns/100ps
`include "fb_memif_cfg.svh"

module rd_burst_seq (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable,
    input  logic                   vsync,
    input  fb_mem_pkg::byte_addr_t frame_bytes,
    output fb_mem_pkg::word_t      pix_read,
    output logic                   pix_read_valid,
    input  logic                   pix_read_ready,
    output logic                   mig_rd_en,
    input  fb_mem_pkg::word_t      mig_rd_data,
    input  logic                   mig_rd_empty,
    output logic                   rd_req,
    output fb_mem_pkg::byte_addr_t rd_addr,
    input  logic                   rd_done
);

    // Words of the current burst not yet handed to the consumer
    typedef logic [$clog2(`FB_BURST_LEN + 1)-1:0] left_t;

    fb_ctrl_pkg::rd_state_t state;
    fb_mem_pkg::byte_addr_t end_addr;
    left_t                  words_left;
    logic                   reading;
    logic                   last_cmd;

    // Straight from the FIFO head to the consumer
    assign reading        = !mig_rd_empty && pix_read_ready;
    assign mig_rd_en      = reading;
    assign pix_read_valid = reading;
    assign pix_read       = mig_rd_data;
    assign rd_req         = (state == fb_ctrl_pkg::RD_ISSUE);
    assign last_cmd       = (rd_addr == end_addr) || !enable;

    always_ff @(posedge clk) begin
        end_addr <= frame_bytes - fb_mem_pkg::byte_addr_t'(`FB_CMD_BYTES);
    end

    // Reloaded per issued burst, counts down as words leave the FIFO
    always_ff @(posedge clk) begin
        if (rst) begin
            words_left <= '0;
        end else if (rd_done) begin
            words_left <= left_t'(`FB_BURST_LEN);
        end else if (reading && (words_left != '0)) begin
            words_left <= words_left - left_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= fb_ctrl_pkg::RD_IDLE;
            rd_addr <= '0;
        end else begin
            case (state)
                fb_ctrl_pkg::RD_IDLE: begin
                    // Leftovers from an aborted frame drain before the first issue
                    if (vsync && enable) begin
                        rd_addr <= '0;
                        state   <= fb_ctrl_pkg::RD_WAIT_DRAIN;
                    end
                end
                fb_ctrl_pkg::RD_WAIT_DATA: begin
                    if (!mig_rd_empty) begin
                        state <= fb_ctrl_pkg::RD_WAIT_DRAIN;
                    end
                end
                fb_ctrl_pkg::RD_WAIT_DRAIN: begin
                    if (mig_rd_empty && (words_left == '0)) begin
                        state <= fb_ctrl_pkg::RD_ISSUE;
                    end
                end
                fb_ctrl_pkg::RD_ISSUE: begin
                    if (rd_done) begin
                        rd_addr <= rd_addr + fb_mem_pkg::byte_addr_t'(`FB_CMD_BYTES);
                        state   <= last_cmd ? fb_ctrl_pkg::RD_IDLE
                                            : fb_ctrl_pkg::RD_WAIT_DATA;
                    end
                end
                default: state <= fb_ctrl_pkg::RD_IDLE;
            endcase
        end
    end

    // A read request never comes straight out of idle
    a_rd_req_not_idle: assert property (@(posedge clk) disable iff (rst)
        rd_req |-> ($past(state) != fb_ctrl_pkg::RD_IDLE));

endmodule

//--- design/wr_burst_seq.sv
// Write burst sequencer: pixel intake, write FIFO push and one write request per burst
`timescale 1ns/100ps
`include "fb_memif_cfg.svh"

module wr_burst_seq (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable,
    input  logic                   vsync,
    input  fb_mem_pkg::byte_addr_t frame_bytes,
    input  fb_mem_pkg::word_t      pix_write,
    input  logic                   pix_write_valid,
    output logic                   pix_write_ready,
    input  logic                   mig_wr_full,
    output logic                   mig_wr_en,
    output fb_mem_pkg::word_t      mig_wr_data,
    output fb_mem_pkg::mask_t      mig_wr_mask,
    output logic                   wr_req,
    output fb_mem_pkg::byte_addr_t wr_addr,
    input  logic                   wr_done
);

    fb_ctrl_pkg::wr_state_t state;
    fb_mem_pkg::burst_cnt_t word_cnt;
    fb_mem_pkg::byte_addr_t end_addr;
    logic                   accept;
    logic                   last_cmd;

    // A word moves whenever the producer offers one and the FIFO has room
    assign accept          = pix_write_valid && !mig_wr_full;
    assign pix_write_ready = accept;
    assign last_cmd        = (wr_addr == end_addr) || !enable;
    assign wr_req          = (state == fb_ctrl_pkg::WR_ISSUE);
    assign mig_wr_mask     = '0;

    // Address of the last command in the frame
    always_ff @(posedge clk) begin
        end_addr <= frame_bytes - fb_mem_pkg::byte_addr_t'(`FB_CMD_BYTES);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= fb_ctrl_pkg::WR_IDLE;
            word_cnt <= '0;
            wr_addr  <= '0;
        end else begin
            case (state)
                fb_ctrl_pkg::WR_IDLE: begin
                    if (vsync) begin
                        wr_addr  <= '0;
                        word_cnt <= fb_mem_pkg::burst_cnt_t'(accept);
                        state    <= fb_ctrl_pkg::WR_PUSH;
                    end
                end
                fb_ctrl_pkg::WR_PUSH: begin
                    // A full burst is buffered, claim it for one command
                    if (word_cnt >= fb_mem_pkg::burst_cnt_t'(`FB_BURST_LEN)) begin
                        word_cnt <= word_cnt + fb_mem_pkg::burst_cnt_t'(accept)
                                    - fb_mem_pkg::burst_cnt_t'(`FB_BURST_LEN);
                        state    <= fb_ctrl_pkg::WR_ISSUE;
                    end else begin
                        word_cnt <= word_cnt + fb_mem_pkg::burst_cnt_t'(accept);
                    end
                end
                fb_ctrl_pkg::WR_ISSUE: begin
                    // Intake continues while the command waits
                    word_cnt <= word_cnt + fb_mem_pkg::burst_cnt_t'(accept);
                    if (wr_done) begin
                        wr_addr <= wr_addr + fb_mem_pkg::byte_addr_t'(`FB_CMD_BYTES);
                        state   <= last_cmd ? fb_ctrl_pkg::WR_IDLE : fb_ctrl_pkg::WR_PUSH;
                    end
                end
                default: state <= fb_ctrl_pkg::WR_IDLE;
            endcase
        end
    end

    // Write FIFO push, one cycle behind acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            mig_wr_en <= 1'b0;
        end else begin
            mig_wr_en <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mig_wr_data <= pix_write;
        end
    end

    // Command addresses stay on burst boundaries across the whole frame
    a_wr_addr_aligned: assert property (@(posedge clk) disable iff (rst)
        (wr_addr % `FB_CMD_BYTES) == 0);

    // Each FIFO push comes from a cycle where the FIFO had room
    a_wr_push_room: assert property (@(posedge clk) disable iff (rst)
        mig_wr_en |-> $past(pix_write_valid && !mig_wr_full));

endmodule

//--- design/fb_ctrl_pkg.sv
// State machine encodings for the write sequencer, read sequencer and command arbiter
`include "fb_memif_cfg.svh"

package fb_ctrl_pkg;

    // Write side, fill a burst then wait for its command
    typedef enum logic [1:0] {
        WR_IDLE  = 2'd0,
        WR_PUSH  = 2'd1,
        WR_ISSUE = 2'd2
    } wr_state_t;

    // Read side, one burst in flight at a time
    typedef enum logic [1:0] {
        RD_IDLE       = 2'd0,
        RD_WAIT_DATA  = 2'd1,
        RD_WAIT_DRAIN = 2'd2,
        RD_ISSUE      = 2'd3
    } rd_state_t;

    // Arbiter, issue cycle followed by one idle cycle
    typedef enum logic {
        ISSUE_WAIT = 1'b0,
        ISSUE_ACT  = 1'b1
    } issue_state_t;

endpackage

//--- design/fb_mem_pkg.sv
// Memory port types: data word, write mask, addresses, burst fields and command opcode
`include "fb_memif_cfg.svh"

package fb_mem_pkg;

    // One data word on the pixel and controller ports
    typedef logic [`FB_WORD_BYTES*8-1:0] word_t;

    // Byte enables for one word, all zero for full writes
    typedef logic [`FB_WORD_BYTES-1:0] mask_t;

    // Byte address inside the framebuffer, also the frame size
    typedef logic [23:0] byte_addr_t;

    // Byte address as seen by the DDR controller
    typedef logic [`FB_MIG_ADDR_BITS-1:0] mig_addr_t;

    // Burst length field, words minus one
    typedef logic [`FB_BL_BITS-1:0] bl_t;

    // Words sitting in the write FIFO that no command has claimed yet
    typedef logic [6:0] burst_cnt_t;

    typedef enum logic [2:0] {
        CMD_WRITE = 3'd0,
        CMD_READ  = 3'd1
    } cmd_instr_t;

endpackage

//--- design/fb_memif_cfg.svh
// Word size, burst length and command size macros for the framebuffer memory port
`ifndef FB_MEMIF_CFG_SVH
`define FB_MEMIF_CFG_SVH

// Bytes carried by one 128-bit data word
`define FB_WORD_BYTES 16

// Words per burst command, never below 2
`define FB_BURST_LEN 8

// Bytes moved by one burst command
`define FB_CMD_BYTES (`FB_WORD_BYTES * `FB_BURST_LEN)

// Width of the controller burst length field
`define FB_BL_BITS 6

// Width of the controller byte address
`define FB_MIG_ADDR_BITS 30

`endif
